// File: logic/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Cache geometry
`define CACHE_WAYS        4
`define CACHE_SETS        16
`define CACHE_LINE_BITS   256

// Address split: tag | index | word offset | byte offset
`define CACHE_TAG_BITS    23
`define CACHE_TAG_LSB     9
`define CACHE_INDEX_BITS  4
`define CACHE_INDEX_LSB   5
`define CACHE_OFFSET_BITS 3
`define CACHE_OFFSET_LSB  2

`endif

// File: logic/cache_types_pkg.sv
`include "cache_cfg.svh"

package cache_types_pkg;

    // Miss handler states
    typedef enum logic [1:0] {
        idle_s,
        compare_tag_s,
        writeback_s,
        allocate_s
    } state_t;

    // Dirty bit sits above the tag
    typedef struct packed {
        logic                       dirty;
        logic [`CACHE_TAG_BITS-1:0] tag;
    } tag_entry_t;

    // Bit 0 picks the way pair, bit 1 ways 0/1, bit 2 ways 2/3
    typedef logic [2:0] plru_t;

    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

endpackage

// File: logic/mem_bus_pkg.sv
`include "cache_cfg.svh"

package mem_bus_pkg;

    // Memory side
    typedef logic [`CACHE_LINE_BITS-1:0] line_t;
    typedef logic [31:0]                 addr_t;

    // CPU side
    typedef logic [31:0] word_t;
    typedef logic [3:0]  bmask_t;

    // One enable per byte of a line
    typedef logic [`CACHE_LINE_BITS/8-1:0] line_mask_t;

endpackage

// File: logic/cache_lookup_if.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

interface cache_lookup_if;

    logic                           hit;
    cache_types_pkg::way_t          hit_way;
    cache_types_pkg::way_t          victim_way;
    logic                           victim_dirty;
    logic [`CACHE_TAG_BITS-1:0]     victim_tag;
    logic [`CACHE_INDEX_BITS-1:0]   index;
    logic [`CACHE_OFFSET_BITS-1:0]  word_sel;
    cache_types_pkg::plru_t         plru;

    modport lookup (
        output hit, hit_way, victim_way, victim_dirty, victim_tag,
        output index, word_sel, plru
    );

    modport control (
        input hit, victim_dirty, victim_tag
    );

    modport datapath (
        input hit, hit_way, victim_way, victim_dirty, victim_tag,
        input index, word_sel, plru
    );

endinterface

// File: logic/ff_array.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module ff_array #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `CACHE_SETS
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  payload_t                 din,
    output payload_t                 dout
);

    payload_t mem [DEPTH];

    // Cleared entries read back as invalid lines and a zero PLRU tree
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= din;
        end
    end

    // Read is combinational so lookup sees the set in the same cycle
    assign dout = mem[addr];

endmodule

// File: logic/cache_lookup.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_lookup (
    input  mem_bus_pkg::addr_t          ufp_addr,
    input  logic                        ways_valid [`CACHE_WAYS],
    input  cache_types_pkg::tag_entry_t ways_tags [`CACHE_WAYS],
    input  cache_types_pkg::plru_t      plru_bits,
    cache_lookup_if.lookup              lk
);

    logic [`CACHE_TAG_BITS-1:0] req_tag;
    logic [`CACHE_WAYS-1:0]     way_match;
    cache_types_pkg::way_t      match_way;
    cache_types_pkg::way_t      victim;

    // Address split
    assign req_tag     = ufp_addr[`CACHE_TAG_LSB +: `CACHE_TAG_BITS];
    assign lk.index    = ufp_addr[`CACHE_INDEX_LSB +: `CACHE_INDEX_BITS];
    assign lk.word_sel = ufp_addr[`CACHE_OFFSET_LSB +: `CACHE_OFFSET_BITS];
    assign lk.plru     = plru_bits;

    // Tag compare in every way
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_match[w] = ways_valid[w] && (ways_tags[w].tag == req_tag);
        end
    end

    // At most one way can match, lowest index wins anyway
    always_comb begin
        match_way = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (way_match[w]) begin
                match_way = cache_types_pkg::way_t'(w);
            end
        end
    end

    assign lk.hit     = |way_match;
    assign lk.hit_way = match_way;

    // Tree walk toward the least recently used leaf
    always_comb begin
        if (plru_bits[0]) begin
            victim = {1'b1, plru_bits[2]};
        end else begin
            victim = {1'b0, plru_bits[1]};
        end
    end

    assign lk.victim_way = victim;

    // Victim details for writeback
    assign lk.victim_dirty = ways_valid[victim] && ways_tags[victim].dirty;
    assign lk.victim_tag   = ways_tags[victim].tag;

endmodule

// File: logic/cache_control.sv
`timescale 1ns/1ps

module cache_control (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ufp_rmask,
    input  mem_bus_pkg::bmask_t     ufp_wmask,
    input  logic                    dfp_resp,
    cache_lookup_if.control         lk,
    output cache_types_pkg::state_t state,
    output logic                    dfp_read,
    output logic                    dfp_write
);

    cache_types_pkg::state_t state_next;
    logic                    req;

    // Read or any byte of a write counts as a request
    assign req = ufp_rmask || (|ufp_wmask);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_types_pkg::idle_s;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            cache_types_pkg::idle_s: begin
                if (req) begin
                    state_next = cache_types_pkg::compare_tag_s;
                end
            end
            cache_types_pkg::compare_tag_s: begin
                // Hit responds here; a miss evicts or refills first
                if (lk.hit) begin
                    state_next = cache_types_pkg::idle_s;
                end else if (lk.victim_dirty) begin
                    state_next = cache_types_pkg::writeback_s;
                end else begin
                    state_next = cache_types_pkg::allocate_s;
                end
            end
            cache_types_pkg::writeback_s: begin
                if (dfp_resp) begin
                    state_next = cache_types_pkg::allocate_s;
                end
            end
            cache_types_pkg::allocate_s: begin
                // Refilled line hits on the second compare
                if (dfp_resp) begin
                    state_next = cache_types_pkg::compare_tag_s;
                end
            end
            default: begin
                state_next = cache_types_pkg::idle_s;
            end
        endcase
    end

    // Requests drop the cycle after dfp_resp with the state change
    assign dfp_write = (state == cache_types_pkg::writeback_s);
    assign dfp_read  = (state == cache_types_pkg::allocate_s);

endmodule

// File: logic/cache_datapath.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_datapath (
    input  cache_types_pkg::state_t     state,
    input  mem_bus_pkg::addr_t          ufp_addr,
    input  mem_bus_pkg::bmask_t         ufp_wmask,
    input  mem_bus_pkg::word_t          ufp_wdata,
    input  mem_bus_pkg::line_t          dfp_rdata,
    input  logic                        dfp_resp,
    input  mem_bus_pkg::line_t          ways_lines [`CACHE_WAYS],
    cache_lookup_if.datapath            lk,
    output mem_bus_pkg::word_t          ufp_rdata,
    output logic                        ufp_resp,
    output mem_bus_pkg::addr_t          dfp_addr,
    output mem_bus_pkg::line_t          dfp_wdata,
    output mem_bus_pkg::line_t          set_lines [`CACHE_WAYS],
    output cache_types_pkg::tag_entry_t set_tags [`CACHE_WAYS],
    output logic                        set_valid [`CACHE_WAYS],
    output logic                        line_we [`CACHE_WAYS],
    output logic                        tag_we [`CACHE_WAYS],
    output logic                        valid_we [`CACHE_WAYS],
    output cache_types_pkg::plru_t      set_plru,
    output logic                        plru_we
);

    mem_bus_pkg::line_t      hit_line;
    mem_bus_pkg::line_t      merged_line;
    mem_bus_pkg::line_mask_t byte_en;
    logic [`CACHE_WAYS-1:0]  refill_way;
    logic [`CACHE_WAYS-1:0]  store_way;
    logic                    compare;
    logic                    allocate;

    assign compare  = (state == cache_types_pkg::compare_tag_s);
    assign allocate = (state == cache_types_pkg::allocate_s);

    // CPU read word from the hit way
    assign hit_line  = ways_lines[lk.hit_way];
    assign ufp_rdata = hit_line[lk.word_sel * $bits(mem_bus_pkg::word_t) +: $bits(ufp_rdata)];
    assign ufp_resp  = compare && lk.hit;

    // Store bytes land in the addressed word only
    always_comb begin
        byte_en = '0;
        byte_en[lk.word_sel * $bits(ufp_wmask) +: $bits(ufp_wmask)] = ufp_wmask;
        for (int b = 0; b < $bits(byte_en); b++) begin
            merged_line[b*8 +: 8] = byte_en[b] ? ufp_wdata[(b % 4)*8 +: 8] : hit_line[b*8 +: 8];
        end
    end

    // Writeback goes to the victim's own line, refill to the requested one
    always_comb begin
        if (state == cache_types_pkg::writeback_s) begin
            dfp_addr = {lk.victim_tag, lk.index, {`CACHE_INDEX_LSB{1'b0}}};
        end else begin
            dfp_addr = {ufp_addr[31:`CACHE_INDEX_LSB], {`CACHE_INDEX_LSB{1'b0}}};
        end
    end

    assign dfp_wdata = ways_lines[lk.victim_way];

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            refill_way[w]     = allocate && dfp_resp && (lk.victim_way == w);
            store_way[w]      = compare && lk.hit && (|ufp_wmask) && (lk.hit_way == w);
            line_we[w]        = refill_way[w] || store_way[w];
            tag_we[w]         = refill_way[w] || store_way[w];
            valid_we[w]       = refill_way[w];
            set_lines[w]      = refill_way[w] ? dfp_rdata : merged_line;
            set_tags[w].dirty = store_way[w];
            set_tags[w].tag   = ufp_addr[`CACHE_TAG_LSB +: `CACHE_TAG_BITS];
            set_valid[w]      = 1'b1;
        end
    end

    // Point the tree away from the way just used
    always_comb begin
        set_plru = lk.plru;
        if (lk.hit_way[1]) begin
            set_plru[0] = 1'b0;
            set_plru[2] = ~lk.hit_way[0];
        end else begin
            set_plru[0] = 1'b1;
            set_plru[1] = ~lk.hit_way[0];
        end
    end

    assign plru_we = compare && lk.hit;

endmodule

// File: logic/cache.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache (
    input  logic                clk,
    input  logic                rst,

    // CPU side
    input  mem_bus_pkg::addr_t  ufp_addr,
    input  logic                ufp_rmask,
    input  mem_bus_pkg::bmask_t ufp_wmask,
    output mem_bus_pkg::word_t  ufp_rdata,
    input  mem_bus_pkg::word_t  ufp_wdata,
    output logic                ufp_resp,

    // Memory side
    output mem_bus_pkg::addr_t  dfp_addr,
    output logic                dfp_read,
    output logic                dfp_write,
    input  mem_bus_pkg::line_t  dfp_rdata,
    output mem_bus_pkg::line_t  dfp_wdata,
    input  logic                dfp_resp
);

    cache_types_pkg::state_t     state;
    cache_types_pkg::plru_t      plru_bits;
    cache_types_pkg::plru_t      set_plru;
    logic                        plru_we;

    // Per-way array reads
    logic                        ways_valid [`CACHE_WAYS];
    cache_types_pkg::tag_entry_t ways_tags [`CACHE_WAYS];
    mem_bus_pkg::line_t          ways_lines [`CACHE_WAYS];

    // Per-way array writes
    logic                        set_valid [`CACHE_WAYS];
    cache_types_pkg::tag_entry_t set_tags [`CACHE_WAYS];
    mem_bus_pkg::line_t          set_lines [`CACHE_WAYS];
    logic                        valid_we [`CACHE_WAYS];
    logic                        tag_we [`CACHE_WAYS];
    logic                        line_we [`CACHE_WAYS];

    cache_lookup_if lk_if ();

    cache_lookup lookup_i (
        .ufp_addr   (ufp_addr),
        .ways_valid (ways_valid),
        .ways_tags  (ways_tags),
        .plru_bits  (plru_bits),
        .lk         (lk_if.lookup)
    );

    cache_control control_i (
        .clk       (clk),
        .rst       (rst),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .dfp_resp  (dfp_resp),
        .lk        (lk_if.control),
        .state     (state),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write)
    );

    cache_datapath datapath_i (
        .state      (state),
        .ufp_addr   (ufp_addr),
        .ufp_wmask  (ufp_wmask),
        .ufp_wdata  (ufp_wdata),
        .dfp_rdata  (dfp_rdata),
        .dfp_resp   (dfp_resp),
        .ways_lines (ways_lines),
        .lk         (lk_if.datapath),
        .ufp_rdata  (ufp_rdata),
        .ufp_resp   (ufp_resp),
        .dfp_addr   (dfp_addr),
        .dfp_wdata  (dfp_wdata),
        .set_lines  (set_lines),
        .set_tags   (set_tags),
        .set_valid  (set_valid),
        .line_we    (line_we),
        .tag_we     (tag_we),
        .valid_we   (valid_we),
        .set_plru   (set_plru),
        .plru_we    (plru_we)
    );

    // One PLRU tree per set
    ff_array #(.payload_t(cache_types_pkg::plru_t)) plru_array (
        .clk  (clk),
        .rst  (rst),
        .we   (plru_we),
        .addr (lk_if.index),
        .din  (set_plru),
        .dout (plru_bits)
    );

    for (genvar i = 0; i < `CACHE_WAYS; i++) begin : g_way
        ff_array #(.payload_t(logic)) valid_array (
            .clk  (clk),
            .rst  (rst),
            .we   (valid_we[i]),
            .addr (lk_if.index),
            .din  (set_valid[i]),
            .dout (ways_valid[i])
        );
        ff_array #(.payload_t(cache_types_pkg::tag_entry_t)) tag_array (
            .clk  (clk),
            .rst  (rst),
            .we   (tag_we[i]),
            .addr (lk_if.index),
            .din  (set_tags[i]),
            .dout (ways_tags[i])
        );
        ff_array #(.payload_t(mem_bus_pkg::line_t)) line_array (
            .clk  (clk),
            .rst  (rst),
            .we   (line_we[i]),
            .addr (lk_if.index),
            .din  (set_lines[i]),
            .dout (ways_lines[i])
        );
    end

endmodule

// File: verification/cache_chk.sv
`timescale 1ns/1ps

module cache_chk (
    input logic               clk,
    input logic               rst,
    input logic               ufp_resp,
    input logic               dfp_read,
    input logic               dfp_write,
    input logic               dfp_resp,
    input mem_bus_pkg::addr_t dfp_addr
);

    int unsigned failures = 0;

    // Memory request drops the cycle after its response
    req_drops: assert property (
        @(posedge clk) disable iff (rst)
        dfp_resp |=> !(dfp_read && $past(dfp_read)) && !(dfp_write && $past(dfp_write))
    ) else begin
        $error("memory request still high in the cycle after dfp_resp");
        failures++;
    end

    // Address holds until the memory answers
    addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (dfp_read || dfp_write) && !dfp_resp |=> $stable(dfp_addr)
    ) else begin
        $error("dfp_addr changed while a memory request was waiting");
        failures++;
    end

    resp_one_cycle: assert property (
        @(posedge clk) disable iff (rst) ufp_resp |=> !ufp_resp
    ) else begin
        $error("ufp_resp stayed high for more than one cycle");
        failures++;
    end

    // Nothing pending in the first cycle out of reset
    quiet_after_reset: assert property (
        @(posedge clk) rst |=> !dfp_read && !dfp_write && !ufp_resp
    ) else begin
        $error("handshake outputs active in the first cycle after reset");
        failures++;
    end

endmodule

// File: verification/cache_tb.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb;

    localparam int          CLK_PERIOD   = 20;
    localparam logic [31:0] SEED         = 32'ha280;
    localparam int          N_DIRECTED   = 11;
    localparam int          N_RANDOM     = 400;
    localparam int          MEM_LAT_MIN  = 1;
    localparam int          MEM_LAT_MAX  = 6;
    // Idle, compare, writeback, allocate and the second compare
    localparam int          WORST_CYCLES = 4 + 2 * (MEM_LAT_MAX + 1);

    logic                clk       = 1'b0;
    logic                rst       = 1'b1;
    mem_bus_pkg::addr_t  ufp_addr  = '0;
    logic                ufp_rmask = 1'b0;
    mem_bus_pkg::bmask_t ufp_wmask = '0;
    mem_bus_pkg::word_t  ufp_wdata = '0;
    mem_bus_pkg::word_t  ufp_rdata;
    logic                ufp_resp;
    mem_bus_pkg::addr_t  dfp_addr;
    logic                dfp_read;
    logic                dfp_write;
    mem_bus_pkg::line_t  dfp_rdata = '0;
    mem_bus_pkg::line_t  dfp_wdata;
    logic                dfp_resp  = 1'b0;

    // Memory model and byte shadow
    mem_bus_pkg::line_t         mem_lines [mem_bus_pkg::addr_t];
    logic [7:0]                 shadow_mem [mem_bus_pkg::addr_t];
    int                         mem_lat;
    int                         mem_cnt;

    // Shadow tags per set
    logic                       sh_valid [`CACHE_SETS][`CACHE_WAYS];
    logic                       sh_dirty [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_TAG_BITS-1:0] sh_tag [`CACHE_SETS][`CACHE_WAYS];
    cache_types_pkg::plru_t     sh_plru [`CACHE_SETS];

    // Expectations for the request in flight
    logic                       exp_hit;
    logic                       exp_wb;
    mem_bus_pkg::addr_t         exp_wb_addr;
    mem_bus_pkg::line_t         exp_wb_data;
    mem_bus_pkg::addr_t         exp_fill_addr;
    mem_bus_pkg::word_t         exp_rdata;
    logic                       op_write;
    logic                       wb_seen;
    logic                       fill_seen;
    int                         errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache dut_i (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_rdata (ufp_rdata),
        .ufp_wdata (ufp_wdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_rdata (dfp_rdata),
        .dfp_wdata (dfp_wdata),
        .dfp_resp  (dfp_resp)
    );

    bind cache cache_chk chk_i (
        .clk       (clk),
        .rst       (rst),
        .ufp_resp  (ufp_resp),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_resp  (dfp_resp),
        .dfp_addr  (dfp_addr)
    );

    // Fill pattern built from every address bit
    function automatic mem_bus_pkg::word_t fill_word(mem_bus_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a3c_c3a5;
    endfunction

    function automatic mem_bus_pkg::line_t read_line(mem_bus_pkg::addr_t a);
        mem_bus_pkg::line_t l;
        if (mem_lines.exists(a)) begin
            return mem_lines[a];
        end
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = fill_word(a + 32'(w * 4));
        end
        return l;
    endfunction

    // Reference word from the byte shadow
    function automatic mem_bus_pkg::word_t expected_word(mem_bus_pkg::addr_t a);
        mem_bus_pkg::word_t w;
        mem_bus_pkg::addr_t base;
        base = {a[31:2], 2'b00};
        w    = fill_word(base);
        for (int b = 0; b < 4; b++) begin
            if (shadow_mem.exists(base + 32'(b))) begin
                w[b*8 +: 8] = shadow_mem[base + 32'(b)];
            end
        end
        return w;
    endfunction

    function automatic mem_bus_pkg::line_t shadow_line(mem_bus_pkg::addr_t a);
        mem_bus_pkg::line_t l;
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = expected_word(a + 32'(w * 4));
        end
        return l;
    endfunction

    // Bit 0 picks the pair, bits 1 and 2 the way inside it
    function automatic int victim_of(cache_types_pkg::plru_t p);
        if (p[0]) begin
            return p[2] ? 3 : 2;
        end
        return p[1] ? 1 : 0;
    endfunction

    // Every node on the path turns toward the other half
    function automatic cache_types_pkg::plru_t touch_tree(cache_types_pkg::plru_t p, int way);
        cache_types_pkg::plru_t n;
        n    = p;
        n[0] = (way < 2);
        if (way < 2) begin
            n[1] = (way == 0);
        end else begin
            n[2] = (way == 2);
        end
        return n;
    endfunction

    function automatic mem_bus_pkg::addr_t make_addr(int tag, int set_idx, int word);
        return {23'(tag), 4'(set_idx), 3'(word), 2'b00};
    endfunction

    task automatic check(input logic [255:0] got, input logic [255:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // Updates the shadow state and sets what the DUT must do next
    task automatic predict(input mem_bus_pkg::addr_t a, input logic wr,
                           input mem_bus_pkg::bmask_t m, input mem_bus_pkg::word_t d);
        int                         idx;
        int                         way;
        logic [`CACHE_TAG_BITS-1:0] tag;
        idx     = a[`CACHE_INDEX_LSB +: `CACHE_INDEX_BITS];
        tag     = a[`CACHE_TAG_LSB +: `CACHE_TAG_BITS];
        exp_hit = 1'b0;
        exp_wb  = 1'b0;
        way     = 0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (sh_valid[idx][w] && sh_tag[idx][w] == tag) begin
                exp_hit = 1'b1;
                way     = w;
            end
        end
        if (!exp_hit) begin
            way           = victim_of(sh_plru[idx]);
            exp_wb        = sh_valid[idx][way] && sh_dirty[idx][way];
            exp_wb_addr   = {sh_tag[idx][way], 4'(idx), 5'b0};
            exp_wb_data   = shadow_line(exp_wb_addr);
            exp_fill_addr = {a[31:5], 5'b0};
            sh_valid[idx][way] = 1'b1;
            sh_dirty[idx][way] = 1'b0;
            sh_tag[idx][way]   = tag;
        end
        sh_plru[idx] = touch_tree(sh_plru[idx], way);
        if (wr) begin
            sh_dirty[idx][way] = 1'b1;
            for (int b = 0; b < 4; b++) begin
                if (m[b]) begin
                    shadow_mem[{a[31:2], 2'(b)}] = d[b*8 +: 8];
                end
            end
        end
        exp_rdata = expected_word(a);
        op_write  = wr;
        wb_seen   = 1'b0;
        fill_seen = 1'b0;
    endtask

    task automatic run_op(input mem_bus_pkg::addr_t a, input logic wr,
                          input mem_bus_pkg::bmask_t m, input mem_bus_pkg::word_t d);
        int cycles;
        @(posedge clk);
        predict(a, wr, m, d);
        ufp_addr  <= a;
        ufp_rmask <= !wr;
        ufp_wmask <= wr ? m : 4'h0;
        ufp_wdata <= d;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ufp_resp);
        if (exp_hit) begin
            check(cycles, 2, "hit latency in cycles");
        end
    endtask

    // Memory answers after a random delay
    always @(posedge clk) begin
        if (rst || dfp_resp) begin
            dfp_resp <= 1'b0;
            mem_lat = 0;
            mem_cnt = 0;
        end else if (dfp_read || dfp_write) begin
            if (mem_lat == 0) begin
                mem_lat = $urandom_range(MEM_LAT_MAX, MEM_LAT_MIN);
            end
            mem_cnt++;
            if (mem_cnt >= mem_lat) begin
                dfp_resp <= 1'b1;
                if (dfp_write) begin
                    mem_lines[dfp_addr] = dfp_wdata;
                end else begin
                    dfp_rdata <= read_line(dfp_addr);
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (dfp_read && dfp_resp) begin
                check(dfp_addr, exp_fill_addr, "refill address");
                fill_seen = 1'b1;
            end
            if (dfp_write && dfp_resp) begin
                check(1'b1, exp_wb, "memory write to a line that was never dirtied");
                check(dfp_addr, exp_wb_addr, "writeback address");
                check(dfp_wdata, exp_wb_data, "writeback data");
                wb_seen = 1'b1;
            end
            if (ufp_resp) begin
                if (!op_write) begin
                    check(ufp_rdata, exp_rdata, "read data");
                end
                check(wb_seen, exp_wb, "writeback before refill");
                check(fill_seen, !exp_hit, "refill on a miss only");
            end
        end
    end

    initial begin : stimulus
        mem_bus_pkg::addr_t a;
        logic               wr;
        void'($urandom(SEED));
        for (int s = 0; s < `CACHE_SETS; s++) begin
            sh_plru[s] = '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
                sh_tag[s][w]   = '0;
            end
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Cold miss, then hits on the same line
        a = make_addr(9, 1, 5);
        run_op(a, 1'b0, 4'h0, '0);
        run_op(a, 1'b0, 4'h0, '0);
        run_op(a - 32'd4, 1'b0, 4'h0, '0);

        // Masked store merged with the old bytes
        run_op(a + 32'd8, 1'b1, 4'($urandom_range(15, 1)), $urandom);
        run_op(a + 32'd8, 1'b0, 4'h0, '0);

        // Five dirty tags in set 3
        for (int t = 0; t < 5; t++) begin
            run_op(make_addr(100 + t, 3, t), 1'b1, 4'hf, $urandom);
        end
        run_op(make_addr(200, 3, 0), 1'b0, 4'h0, '0);

        for (int i = 0; i < N_RANDOM; i++) begin
            a  = make_addr(40 + $urandom_range(5, 0), $urandom_range(3, 0),
                           $urandom_range(7, 0));
            wr = $urandom_range(1, 0);
            run_op(a, wr, wr ? 4'($urandom_range(15, 1)) : 4'h0, $urandom);
        end

        @(posedge clk);
        ufp_rmask <= 1'b0;
        ufp_wmask <= 4'h0;
        repeat (4) @(posedge clk);
        if (errors == 0 && dut_i.chk_i.failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #((N_DIRECTED + N_RANDOM) * WORST_CYCLES * CLK_PERIOD + 10 * CLK_PERIOD);
        $display("Timeout: the cache stopped responding before all operations completed");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: files.f
+incdir+logic
logic/cache_types_pkg.sv
logic/mem_bus_pkg.sv
logic/cache_lookup_if.sv
logic/ff_array.sv
logic/cache_lookup.sv
logic/cache_control.sv
logic/cache_datapath.sv
logic/cache.sv
verification/cache_chk.sv
verification/cache_tb.sv

// File: Bender.yml
package:
  name: cache

export_include_dirs:
  - logic

sources:
  - logic/cache_types_pkg.sv
  - logic/mem_bus_pkg.sv
  - logic/cache_lookup_if.sv
  - logic/ff_array.sv
  - logic/cache_lookup.sv
  - logic/cache_control.sv
  - logic/cache_datapath.sv
  - logic/cache.sv
  - target: test
    files:
      - verification/cache_chk.sv
      - verification/cache_tb.sv
